// File: fetch_pc_gen.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

// fetch pc register
// redirect wins over the predicted next pc
module fetch_pc_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        advance_i,       // a word was accepted this cycle
    input  logic [`INST_ADDR_WIDTH-1:0] pred_next_pc_i,
    input  logic                        redirect_i,
    input  logic [`INST_ADDR_WIDTH-1:0] redirect_pc_i,
    output logic [`INST_ADDR_WIDTH-1:0] fetch_pc_o
);

    logic [`INST_ADDR_WIDTH-1:0] pc_q;
    logic [`INST_ADDR_WIDTH-1:0] redirect_aligned;

    // word aligned, no compressed support
    assign redirect_aligned = {redirect_pc_i[`INST_ADDR_WIDTH-1:2], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_aligned;      // execute knows better
        end else if (advance_i) begin
            pc_q <= pred_next_pc_i;        // follow the static prediction
        end
    end

    assign fetch_pc_o = pc_q;

endmodule

// File: fetch_queue.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

// circular buffer between fetch and decode
// valid/ready on the decode side
module fetch_queue #(
    parameter int DEPTH = `FQ_DEPTH  // power of two, 2 or more
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,      // redirect, drop everything
    input  logic                     inflight_i,   // a request is outstanding
    input  logic                     push_i,
    input  sbp_fetch_pkg::fq_entry_t push_entry_i,
    output sbp_fetch_pkg::fq_entry_t pop_entry_o,
    output logic                     deq_valid_o,
    input  logic                     deq_ready_i,
    output logic                     full_o        // no slot left for a new request
);

    import sbp_fetch_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(DEPTH);

    fq_entry_t          mem [DEPTH];   // payload only
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;       // entries held
    logic [PTR_W+1:0]   occupied;      // held plus reserved
    logic               wr_en;
    logic               rd_en;

    assign wr_en = push_i && !flush_i;
    assign rd_en = deq_valid_o && deq_ready_i && !flush_i;

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr_q] <= push_entry_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + PTR_W'(1);   // wraps, power of two
            if (rd_en) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + (PTR_W+1)'(1);
                2'b01:   count_q <= count_q - (PTR_W+1)'(1);
                default: ;                                  // both or none
            endcase
        end
    end

    // outstanding request already owns a slot
    assign occupied = {1'b0, count_q} + {{(PTR_W+1){1'b0}}, inflight_i};
    assign full_o   = occupied >= {1'b0, FULL_CNT};

    assign deq_valid_o = (count_q != '0);
    assign pop_entry_o = mem[rd_ptr_q];

endmodule

// File: imem_req_ctrl.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

// four-phase master toward instruction memory
// req up, ack up, req down, ack down, then next req
module imem_req_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`INST_ADDR_WIDTH-1:0] fetch_pc_i,   // address for the next request
    input  logic                        fq_full_i,    // queue has no free slot
    input  logic                        redirect_i,   // execute redirect pulse
    output logic                        imem_req_o,
    output logic [`INST_ADDR_WIDTH-1:0] imem_addr_o,
    input  logic                        imem_ack_i,
    input  logic [`INST_DATA_WIDTH-1:0] imem_rdata_i,
    output logic                        inst_valid_o, // one cycle, word usable
    output sbp_fetch_pkg::rv_inst_u     inst_o,
    output logic [`INST_ADDR_WIDTH-1:0] inst_pc_o
);

    typedef enum logic [1:0] {
        IDLE,         // nothing outstanding
        WAIT_ACK,     // req high, waiting for data
        WAIT_RELEASE  // req low, waiting for ack to drop
    } state_e;

    state_e                        state_q;
    logic [`INST_ADDR_WIDTH-1:0]   addr_q;   // held for the whole request
    logic                          stale_q;  // in-flight word belongs to an old path
    logic                          ack_taken;
    logic                          can_issue;

    assign ack_taken = (state_q == WAIT_ACK) && imem_ack_i;

    // new req only once ack is seen low, and not in a redirect cycle
    // since fetch_pc_i still holds the old path then
    assign can_issue = !imem_ack_i && !fq_full_i && !redirect_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (can_issue) state_q <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    if (imem_ack_i) state_q <= WAIT_RELEASE; // req drops here
                end
                WAIT_RELEASE: begin
                    if (!imem_ack_i) state_q <= can_issue ? WAIT_ACK : IDLE; // back to back
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // address latch, loaded whenever a req is about to rise
    always_ff @(posedge clk) begin
        if (can_issue && (state_q == IDLE || state_q == WAIT_RELEASE)) begin
            addr_q <= fetch_pc_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stale_q <= 1'b0;
        end else if (ack_taken) begin
            stale_q <= 1'b0;                   // dropped word, path is clean again
        end else if (redirect_i && state_q == WAIT_ACK) begin
            stale_q <= 1'b1;                   // kill the word when it lands
        end
    end

    assign imem_req_o  = (state_q == WAIT_ACK);
    assign imem_addr_o = addr_q;

    // redirect in the ack cycle kills the word too
    assign inst_valid_o = ack_taken && !stale_q && !redirect_i;
    assign inst_o       = imem_rdata_i;
    assign inst_pc_o    = addr_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the fetch testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sbp_fetch.f --top-module sbp_fetch_tb -o sbp_fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sbp_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sbp_fetch.f
+incdir+.
sbp_fetch_pkg.sv
imem_req_ctrl.sv
static_branch_pred.sv
fetch_pc_gen.sv
fetch_queue.sv
sbp_fetch_top.sv
sbp_fetch_assert.sv
sbp_fetch_tb.sv

// File: sbp_fetch_assert.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

module sbp_fetch_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        imem_req_i,
    input logic                        imem_ack_i,
    input logic [`INST_ADDR_WIDTH-1:0] imem_addr_i,
    input logic                        push_i,      // accepted word
    input logic                        flush_i,     // redirect
    input logic                        deq_valid_i,
    input logic                        deq_ready_i
);

    logic [3:0] occ;   // entries held, tracked here

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= '0;
        end else if (flush_i) begin
            occ <= '0;
        end else begin
            occ <= occ + 4'(push_i) - 4'(deq_valid_i && deq_ready_i);
        end
    end

    req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_i && !imem_ack_i |=> imem_req_i)
        else $error("req dropped before ack");

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_i && !imem_ack_i |=> $stable(imem_addr_i))
        else $error("address moved during a request");

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> occ < 4'(`FQ_DEPTH))
        else $error("push into a full queue");

    deq_idle_reset: assert property (@(posedge clk) !rst_n |-> !deq_valid_i)
        else $error("deq_valid high in reset");

endmodule

bind sbp_fetch_top sbp_fetch_assert i_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req_i  (imem_req_o),
    .imem_ack_i  (imem_ack_i),
    .imem_addr_i (imem_addr_o),
    .push_i      (inst_valid),
    .flush_i     (redirect_valid_i),
    .deq_valid_i (deq_valid_o),
    .deq_ready_i (deq_ready_i)
);

// File: sbp_fetch_macros.svh
`ifndef SBP_FETCH_MACROS_SVH
`define SBP_FETCH_MACROS_SVH

// fetch address width, pc and all pc arithmetic
`define INST_ADDR_WIDTH 32

// instruction word width, rv32 without compressed
`define INST_DATA_WIDTH 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// fetch queue entries, keep a power of two of at least 2
`define FQ_DEPTH 4

// byte step between two sequential instructions
`define INST_BYTES 4

`endif

// File: sbp_fetch_pkg.sv
`include "sbp_fetch_macros.svh"

package sbp_fetch_pkg;

    // major opcodes the predictor cares about
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011, // beq bne blt bge bltu bgeu
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OTHER  = 7'b0000000  // everything else, falls through
    } rv_opcode_e;

    // b-type field layout
    typedef struct packed {
        logic       imm12;   // sign bit of the offset
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_btype_t;

    // j-type field layout
    typedef struct packed {
        logic       imm20;   // sign bit of the offset
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_jtype_t;

    // same fetched word, read as branch or as jal
    typedef union packed {
        rv_btype_t b;
        rv_jtype_t j;
    } rv_inst_u;

    // one fetch queue slot, 97 bits
    typedef struct packed {
        rv_inst_u                   inst;
        logic [`INST_ADDR_WIDTH-1:0] pc;
        logic                        pred_taken;
        logic [`INST_ADDR_WIDTH-1:0] recover_pc;  // path not followed
    } fq_entry_t;

endpackage

// File: sbp_fetch_tb.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

module sbp_fetch_tb;

    import sbp_fetch_pkg::*;

    localparam int MEM_WORDS  = 256;                   // 1 KiB, index is addr[9:2]
    localparam int EXP_INSTS  = 29;                    // entries checked over all tests
    localparam int MAX_CYCLES = 40 * EXP_INSTS + 200;

    logic                        clk;
    logic                        rst_n;
    logic                        imem_req_o;
    logic [`INST_ADDR_WIDTH-1:0] imem_addr_o;
    logic                        imem_ack_i   = 1'b0;  // memory model owns these two
    logic [`INST_DATA_WIDTH-1:0] imem_rdata_i = '0;
    logic                        redirect_valid_i;
    logic [`INST_ADDR_WIDTH-1:0] redirect_pc_i;
    logic                        deq_valid_o;
    logic                        deq_ready_i;
    logic [`INST_DATA_WIDTH-1:0] deq_inst_o;
    logic [`INST_ADDR_WIDTH-1:0] deq_pc_o;
    logic                        deq_pred_taken_o;
    logic [`INST_ADDR_WIDTH-1:0] deq_recover_pc_o;

    logic [`INST_DATA_WIDTH-1:0] imem [MEM_WORDS];
    logic [15:0]                 lfsr_q = 16'd49672;
    logic [`INST_ADDR_WIDTH-1:0] exp_pc;               // pc of the next entry to leave
    int                          wait_cnt = 0;         // memory latency left
    int                          cycles   = 0;
    int                          req_rises = 0;
    logic                        req_prev = 1'b0;
    int                          err_cnt = 0;
    int                          chk_cnt = 0;
    int                          jal_k;

    sbp_fetch_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois, one step per bit taken
    function automatic int rand_bits(input int n);
        int   val;
        logic lsb;
        val = 0;
        for (int k = 0; k < n; k++) begin
            lsb    = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (lsb) lfsr_q = lfsr_q ^ 16'hB400;
            val = (val << 1) | {31'd0, lsb};
        end
        return val;
    endfunction

    function automatic logic [31:0] bne_word(input int off);   // bne x1, x2
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input int off);   // jal x1
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
    endfunction

    // btfn rule on the raw word
    task automatic predict_ref(input logic [31:0] pc, input logic [31:0] w,
                               output logic taken, output logic [31:0] nxt,
                               output logic [31:0] rec);
        logic [31:0] bimm;
        logic [31:0] jimm;
        bimm  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        jimm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        taken = 1'b0;
        nxt   = pc + 32'd4;
        rec   = pc + 32'd4;
        if (w[6:0] == 7'b1100011) begin
            if (w[31]) begin
                taken = 1'b1;
                nxt   = pc + bimm;   // loop back
            end else begin
                rec   = pc + bimm;   // forward target kept for recovery
            end
        end else if (w[6:0] == 7'b1101111) begin
            taken = 1'b1;
            nxt   = pc + jimm;
        end
    endtask

    task automatic compare_inst(input string name, input rv_inst_u got, input rv_inst_u exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input logic [`INST_ADDR_WIDTH-1:0] got,
                                input logic [`INST_ADDR_WIDTH-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        chk_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // four-phase slave, 1..3 cycles to ack
    always @(negedge clk) begin
        if (!rst_n) begin
            imem_ack_i <= 1'b0;
            wait_cnt   = 0;
        end else if (imem_ack_i) begin
            if (!imem_req_o) imem_ack_i <= 1'b0;         // req gone, release
        end else if (wait_cnt > 0) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                imem_ack_i   <= 1'b1;
                imem_rdata_i <= imem[imem_addr_o[9:2]];
            end
        end else if (imem_req_o) begin
            wait_cnt = 1 + rand_bits(2) % 3;              // fresh request
        end
    end

    always @(posedge clk) begin
        req_prev <= imem_req_o;
        if (imem_req_o && !req_prev) req_rises <= req_rises + 1;
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic redirect_to(input logic [31:0] pc);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        @(negedge clk);
        redirect_valid_i = 1'b0;
        exp_pc           = pc;
    endtask

    // pops n entries and checks each against the reference rule
    task automatic pop_and_check(input int n);
        logic [31:0] word;
        logic        taken;
        logic [31:0] nxt;
        logic [31:0] rec;
        int          k;
        deq_ready_i = 1'b1;
        for (k = 0; k < n; k++) begin
            while (!deq_valid_o) @(negedge clk);
            word = imem[exp_pc[9:2]];
            predict_ref(exp_pc, word, taken, nxt, rec);
            compare_addr("deq_pc_o", deq_pc_o, exp_pc);
            compare_inst("deq_inst_o", deq_inst_o, word);
            compare_flag("deq_pred_taken_o", deq_pred_taken_o, taken);
            compare_addr("deq_recover_pc_o", deq_recover_pc_o, rec);
            exp_pc = nxt;
            @(negedge clk);                               // entry left on the posedge
        end
        deq_ready_i = 1'b0;
    endtask

    task automatic straight_line();
        pop_and_check(6);                                 // fill words only, from reset pc
    endtask

    task automatic backward_loop();
        imem[131] = bne_word(-8);                         // 0x20c back to 0x204
        redirect_to(32'h0000_0200);
        pop_and_check(7);                                 // goes round the loop twice
    endtask

    task automatic forward_and_jumps();
        imem[192] = bne_word(12);                         // forward, not taken
        imem[194] = jal_word(4 * jal_k);
        imem[194 + jal_k] = 32'h0000_8067;                // jalr x0, 0(x1)
        redirect_to(32'h0000_0300);
        pop_and_check(5);
    endtask

    task automatic redirect_mid_fetch();
        redirect_to(32'h0000_0080);
        while (!(imem_req_o && imem_addr_o == 32'h0000_0088)) @(negedge clk);
        compare_flag("deq_valid_o", deq_valid_o, 1'b1);   // 0x080 and 0x084 queued
        redirect_to(32'h0000_0040);                       // 0x088 word is now stale
        compare_flag("deq_valid_o", deq_valid_o, 1'b0);   // queue flushed
        pop_and_check(4);
    endtask

    task automatic queue_back_pressure();
        int base;
        redirect_to(32'h0000_0140);
        base = req_rises;
        repeat (60) @(negedge clk);                       // ready held low the whole time
        compare_count("imem_req_o rises", req_rises - base, `FQ_DEPTH);
        compare_flag("imem_req_o", imem_req_o, 1'b0);
        pop_and_check(7);
    endtask

    initial begin
        rst_n            = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        deq_ready_i      = 1'b0;
        exp_pc           = `RESET_PC;
        for (int i = 0; i < MEM_WORDS; i++) imem[i] = {25'(i), 7'b0010011}; // addi, unique
        jal_k = 2 + rand_bits(3);                         // jal lands 2..9 words ahead
        repeat (4) @(negedge clk);
        compare_flag("imem_req_o", imem_req_o, 1'b0);
        compare_flag("deq_valid_o", deq_valid_o, 1'b0);
        rst_n = 1'b1;
        straight_line();
        backward_loop();
        forward_and_jumps();
        redirect_mid_fetch();
        queue_back_pressure();
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sbp_fetch_top.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

// fetch front end with static branch prediction
module sbp_fetch_top (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        imem_req_o,
    output logic [`INST_ADDR_WIDTH-1:0] imem_addr_o,
    input  logic                        imem_ack_i,
    input  logic [`INST_DATA_WIDTH-1:0] imem_rdata_i,
    input  logic                        redirect_valid_i,
    input  logic [`INST_ADDR_WIDTH-1:0] redirect_pc_i,
    output logic                        deq_valid_o,
    input  logic                        deq_ready_i,
    output logic [`INST_DATA_WIDTH-1:0] deq_inst_o,
    output logic [`INST_ADDR_WIDTH-1:0] deq_pc_o,
    output logic                        deq_pred_taken_o,
    output logic [`INST_ADDR_WIDTH-1:0] deq_recover_pc_o
);

    import sbp_fetch_pkg::*;

    logic [`INST_ADDR_WIDTH-1:0] fetch_pc;
    logic                        fq_full;
    logic                        inst_valid;   // accepted word, one cycle
    rv_inst_u                    inst;
    logic [`INST_ADDR_WIDTH-1:0] inst_pc;
    logic                        pred_taken;
    logic [`INST_ADDR_WIDTH-1:0] next_pc;
    logic [`INST_ADDR_WIDTH-1:0] recover_pc;
    fq_entry_t                   push_entry;
    fq_entry_t                   pop_entry;

    imem_req_ctrl i_req_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_pc_i   (fetch_pc),
        .fq_full_i    (fq_full),
        .redirect_i   (redirect_valid_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_ack_i   (imem_ack_i),
        .imem_rdata_i (imem_rdata_i),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .inst_pc_o    (inst_pc)
    );

    static_branch_pred i_pred (
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .pc_i         (inst_pc),
        .pred_taken_o (pred_taken),
        .next_pc_o    (next_pc),
        .recover_pc_o (recover_pc)
    );

    fetch_pc_gen i_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .advance_i      (inst_valid),
        .pred_next_pc_i (next_pc),
        .redirect_i     (redirect_valid_i),
        .redirect_pc_i  (redirect_pc_i),
        .fetch_pc_o     (fetch_pc)
    );

    // entry built from the word and its prediction, same cycle
    assign push_entry = '{inst: inst, pc: inst_pc, pred_taken: pred_taken,
                          recover_pc: recover_pc};

    fetch_queue #(
        .DEPTH (`FQ_DEPTH)
    ) i_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (redirect_valid_i),
        .inflight_i   (imem_req_o),     // req high means one word still to come
        .push_i       (inst_valid),
        .push_entry_i (push_entry),
        .pop_entry_o  (pop_entry),
        .deq_valid_o  (deq_valid_o),
        .deq_ready_i  (deq_ready_i),
        .full_o       (fq_full)
    );

    // unpack toward decode
    assign deq_inst_o       = pop_entry.inst;
    assign deq_pc_o         = pop_entry.pc;
    assign deq_pred_taken_o = pop_entry.pred_taken;
    assign deq_recover_pc_o = pop_entry.recover_pc;

endmodule

// File: static_branch_pred.sv
`timescale 1ns/1ps
`include "sbp_fetch_macros.svh"

// backward taken, forward not taken
// jal always taken, jalr never predicted (no register read in fetch)
module static_branch_pred (
    input  logic                        inst_valid_i,
    input  sbp_fetch_pkg::rv_inst_u     inst_i,
    input  logic [`INST_ADDR_WIDTH-1:0] pc_i,
    output logic                        pred_taken_o,
    output logic [`INST_ADDR_WIDTH-1:0] next_pc_o,    // where fetch goes next
    output logic [`INST_ADDR_WIDTH-1:0] recover_pc_o  // where fetch goes on mispredict
);

    import sbp_fetch_pkg::*;

    rv_opcode_e                    op_class;
    logic [`INST_ADDR_WIDTH-1:0]   b_imm;
    logic [`INST_ADDR_WIDTH-1:0]   j_imm;
    logic [`INST_ADDR_WIDTH-1:0]   pc_seq;     // pc+4
    logic [`INST_ADDR_WIDTH-1:0]   b_target;
    logic [`INST_ADDR_WIDTH-1:0]   j_target;
    logic                          br_backward;

    // opcode classification
    always_comb begin
        case (inst_i.b.opcode)
            OP_BRANCH: op_class = OP_BRANCH;
            OP_JAL:    op_class = OP_JAL;
            OP_JALR:   op_class = OP_JALR;
            default:   op_class = OP_OTHER;
        endcase
    end

    // 13 bit b offset, sign extended
    assign b_imm = {{(`INST_ADDR_WIDTH-13){inst_i.b.imm12}}, inst_i.b.imm12,
                    inst_i.b.imm11, inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};

    // 21 bit j offset, sign extended
    assign j_imm = {{(`INST_ADDR_WIDTH-21){inst_i.j.imm20}}, inst_i.j.imm20,
                    inst_i.j.imm19_12, inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};

    assign pc_seq   = pc_i + `INST_ADDR_WIDTH'(`INST_BYTES);
    assign b_target = pc_i + b_imm;
    assign j_target = pc_i + j_imm;

    assign br_backward = inst_i.b.imm12; // negative offset means loop

    always_comb begin
        pred_taken_o = 1'b0;
        next_pc_o    = pc_seq;
        recover_pc_o = pc_seq;   // jalr and other, both ways sequential
        case (op_class)
            OP_BRANCH: begin
                if (br_backward) begin
                    pred_taken_o = inst_valid_i;
                    next_pc_o    = b_target;
                    recover_pc_o = pc_seq;     // fall-through if not taken after all
                end else begin
                    recover_pc_o = b_target;   // forward target if taken after all
                end
            end
            OP_JAL: begin
                pred_taken_o = inst_valid_i;
                next_pc_o    = j_target;
            end
            default: ;
        endcase
    end

endmodule
